// ==== hw/calc_pkg.sv ====
`default_nettype none

package calc_pkg;

    // Keypad geometry
    localparam int NUM_COLS  = 4;
    localparam int NUM_ROWS  = 4;
    localparam int KEY_COUNT = NUM_COLS * NUM_ROWS;  // One bit per key
    localparam int COL_BITS  = 2;

    // A board build raises both debounce values together
    localparam int TIMER_BITS = 5;
    localparam logic [TIMER_BITS-1:0] DEBOUNCE_CYCLES = 5'd16;  // Short for simulation

    // Calculator word width
    localparam int DATA_BITS = 16;

    // Keypad scanner states
    typedef enum logic [2:0] {
        S_IDLE,
        S_SCAN,
        S_DEBOUNCE,
        S_PROCESS,
        S_RELEASE
    } scan_state_t;

    // Operator keys from the top of column 3 down
    typedef enum logic [1:0] {
        OP_ADD,
        OP_SUB,
        OP_MUL,
        OP_NEG
    } calc_op_t;

endpackage

`default_nettype wire

// ==== hw/scan_timer.sv ====
`default_nettype none

module scan_timer (
    input  logic                          clk,
    input  logic                          nRST,
    input  logic                          scan_en,
    input  logic                          timer_run,
    input  logic                          timer_clear,
    output logic [calc_pkg::COL_BITS-1:0] col_index,
    output logic                          timer_done
);

    logic [calc_pkg::TIMER_BITS-1:0] count;  // Debounce count

    // Column index walks all columns while scanning is enabled
    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            col_index <= '0;
        end else if (scan_en) begin
            col_index <= col_index + 1'b1;  // Wraps after last column
        end
    end

    // Debounce counter saturates at the interval
    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            count <= '0;
        end else if (timer_clear) begin
            count <= '0;
        end else if (timer_run && (count != calc_pkg::DEBOUNCE_CYCLES)) begin
            count <= count + 1'b1;
        end
    end

    assign timer_done = (count == calc_pkg::DEBOUNCE_CYCLES);  // Held until cleared

endmodule

`default_nettype wire

// ==== hw/keypad_scan_fsm.sv ====
`default_nettype none

module keypad_scan_fsm (
    input  logic clk,
    input  logic nRST,
    input  logic matrix_changed,
    input  logic matrix_empty,
    input  logic timer_done,
    output logic scan_en,
    output logic timer_run,
    output logic timer_clear,
    output logic process
);

    calc_pkg::scan_state_t state;
    calc_pkg::scan_state_t state_next;

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state <= calc_pkg::S_IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next  = state;
        timer_run   = 1'b0;
        timer_clear = 1'b0;
        process     = 1'b0;
        case (state)
            calc_pkg::S_IDLE: begin
                state_next = calc_pkg::S_SCAN;
            end
            calc_pkg::S_SCAN: begin
                if (!matrix_empty) begin
                    state_next  = calc_pkg::S_DEBOUNCE;
                    timer_clear = 1'b1;  // Fresh debounce interval
                end
            end
            calc_pkg::S_DEBOUNCE: begin
                timer_run = 1'b1;
                if (matrix_empty) begin
                    state_next = calc_pkg::S_SCAN;  // Bounce or glitch
                end else if (matrix_changed) begin
                    timer_clear = 1'b1;  // Contacts still moving
                end else if (timer_done) begin
                    state_next = calc_pkg::S_PROCESS;
                end
            end
            calc_pkg::S_PROCESS: begin
                process     = 1'b1;
                timer_clear = 1'b1;
                state_next  = calc_pkg::S_RELEASE;
            end
            calc_pkg::S_RELEASE: begin
                timer_run = 1'b1;
                if (!matrix_empty) begin
                    timer_clear = 1'b1;  // Key still down
                end else if (timer_done) begin
                    state_next = calc_pkg::S_SCAN;
                end
            end
            default: begin
                state_next = calc_pkg::S_IDLE;
            end
        endcase
    end

    assign scan_en = (state != calc_pkg::S_IDLE);

    // Each process pulse starts a fresh release wait
    assert property (@(posedge clk) disable iff (!nRST)
        process |=> (!process && (state == calc_pkg::S_RELEASE) && !timer_done));

endmodule

`default_nettype wire

// ==== hw/key_matrix.sv ====
`default_nettype none

module key_matrix (
    input  logic                           clk,
    input  logic                           nRST,
    input  logic [calc_pkg::NUM_ROWS-1:0]  row,
    input  logic [calc_pkg::COL_BITS-1:0]  col_index,
    output logic [calc_pkg::NUM_COLS-1:0]  col,
    output logic [calc_pkg::KEY_COUNT-1:0] matrix,
    output logic                           matrix_changed,
    output logic                           matrix_empty
);

    logic [calc_pkg::COL_BITS-1:0] prev_index;  // Column currently on the pins
    logic                          drive_valid;  // Column drive has started
    logic [calc_pkg::NUM_ROWS-1:0] pressed;

    assign pressed = ~row;  // Rows pulled low by a closed key

    // Registered active low column drive
    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            col         <= '1;
            prev_index  <= '0;
            drive_valid <= 1'b0;
        end else begin
            col         <= ~({{(calc_pkg::NUM_COLS-1){1'b0}}, 1'b1} << col_index);
            prev_index  <= col_index;
            drive_valid <= 1'b1;
        end
    end

    // Row capture into the slot of the driven column
    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            matrix         <= '0;
            matrix_changed <= 1'b0;
        end else if (drive_valid) begin
            matrix[prev_index*calc_pkg::NUM_ROWS +: calc_pkg::NUM_ROWS] <= pressed;
            matrix_changed <=
                (matrix[prev_index*calc_pkg::NUM_ROWS +: calc_pkg::NUM_ROWS] != pressed);
        end else begin
            matrix_changed <= 1'b0;
        end
    end

    assign matrix_empty = ~|matrix;

    // Exactly one column is pulled low once driving starts
    assert property (@(posedge clk) disable iff (!nRST)
        drive_valid |-> $onehot(~col));

endmodule

`default_nettype wire

// ==== hw/key_decoder.sv ====
`default_nettype none

module key_decoder (
    input  logic                           clk,
    input  logic                           nRST,
    input  logic                           process,
    input  logic [calc_pkg::KEY_COUNT-1:0] matrix,
    output logic                           digit_strobe,
    output logic [3:0]                     digit,
    output logic                           op_strobe,
    output calc_pkg::calc_op_t             op,
    output logic                           equal_strobe,
    output logic                           clear_strobe,
    output logic                           key_accept
);

    logic [$clog2(calc_pkg::KEY_COUNT)-1:0] key_idx;
    logic                                   single_key;

    assign single_key = $onehot(matrix);  // Rollover is ignored

    // Position of the set bit as col*4 + row
    always_comb begin
        key_idx = '0;
        for (int i = 0; i < calc_pkg::KEY_COUNT; i++) begin
            if (matrix[i]) begin
                key_idx = i[$clog2(calc_pkg::KEY_COUNT)-1:0];
            end
        end
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            digit_strobe <= 1'b0;
            op_strobe    <= 1'b0;
            equal_strobe <= 1'b0;
            clear_strobe <= 1'b0;
        end else begin
            digit_strobe <= process && single_key && (key_idx[3:2] != 2'd3)
                            && (key_idx != 4'd3) && (key_idx != 4'd11);
            op_strobe    <= process && single_key && (key_idx[3:2] == 2'd3);
            equal_strobe <= process && single_key && (key_idx == 4'd3);   // '*'
            clear_strobe <= process && single_key && (key_idx == 4'd11);  // '#'
        end
    end

    // Key values travel alongside their strobes
    always_ff @(posedge clk) begin
        if (process) begin
            case (key_idx)
                4'd0:    digit <= 4'd1;
                4'd1:    digit <= 4'd4;
                4'd2:    digit <= 4'd7;
                4'd4:    digit <= 4'd2;
                4'd5:    digit <= 4'd5;
                4'd6:    digit <= 4'd8;
                4'd7:    digit <= 4'd0;
                4'd8:    digit <= 4'd3;
                4'd9:    digit <= 4'd6;
                4'd10:   digit <= 4'd9;
                default: digit <= 4'd0;
            endcase
            op <= calc_pkg::calc_op_t'(key_idx[1:0]);  // A, B, C, D by row
        end
    end

    assign key_accept = digit_strobe | op_strobe | equal_strobe | clear_strobe;

    // Only one key event per cycle reaches the core
    assert property (@(posedge clk) disable iff (!nRST)
        $onehot0({digit_strobe, op_strobe, equal_strobe, clear_strobe}));

endmodule

`default_nettype wire

// ==== hw/calc_core.sv ====
`default_nettype none

module calc_core (
    input  logic                           clk,
    input  logic                           nRST,
    input  logic                           digit_strobe,
    input  logic [3:0]                     digit,
    input  logic                           op_strobe,
    input  calc_pkg::calc_op_t             op,
    input  logic                           equal_strobe,
    input  logic                           clear_strobe,
    output logic [calc_pkg::DATA_BITS-1:0] display,
    output logic [calc_pkg::DATA_BITS-1:0] result,
    output logic                           result_valid
);

    logic [calc_pkg::DATA_BITS-1:0] entry;       // Number being typed
    logic [calc_pkg::DATA_BITS-1:0] acc;         // Left operand so far
    calc_pkg::calc_op_t             pending_op;  // Applied on next operator or equals
    logic [calc_pkg::DATA_BITS-1:0] applied;
    logic [calc_pkg::DATA_BITS-1:0] shifted;     // Entry times ten plus digit

    function automatic logic [calc_pkg::DATA_BITS-1:0] apply_op(
        input calc_pkg::calc_op_t             op_sel,
        input logic [calc_pkg::DATA_BITS-1:0] a,
        input logic [calc_pkg::DATA_BITS-1:0] b
    );
        case (op_sel)
            calc_pkg::OP_SUB: return a - b;
            calc_pkg::OP_MUL: return a * b;  // Wraps
            default:          return a + b;  // Negate never becomes pending
        endcase
    endfunction

    assign applied = apply_op(pending_op, acc, entry);
    assign shifted = entry * 16'd10 + {12'b0, digit};

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            entry        <= '0;
            acc          <= '0;
            pending_op   <= calc_pkg::OP_ADD;
            display      <= '0;
            result       <= '0;
            result_valid <= 1'b0;
        end else begin
            result_valid <= 1'b0;
            if (clear_strobe) begin
                entry      <= '0;
                acc        <= '0;
                pending_op <= calc_pkg::OP_ADD;
                display    <= '0;
                result     <= '0;
            end else if (digit_strobe) begin
                entry   <= shifted;
                display <= shifted;
            end else if (op_strobe && (op == calc_pkg::OP_NEG)) begin
                entry   <= -entry;  // Acts on the entry only
                display <= -entry;
            end else if (op_strobe) begin
                acc        <= applied;
                pending_op <= op;
                entry      <= '0;
                display    <= applied;  // Running total
            end else if (equal_strobe) begin
                result       <= applied;
                result_valid <= 1'b1;
                entry        <= applied;  // Lets the result feed the next operator
                acc          <= '0;
                pending_op   <= calc_pkg::OP_ADD;
                display      <= applied;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/keypad_calc_top.sv ====
`default_nettype none

module keypad_calc_top (
    input  logic                           clk,
    input  logic                           nRST,
    input  logic [calc_pkg::NUM_ROWS-1:0]  row,
    output logic [calc_pkg::NUM_COLS-1:0]  col,
    output logic [calc_pkg::DATA_BITS-1:0] display,
    output logic [calc_pkg::DATA_BITS-1:0] result,
    output logic                           result_valid,
    output logic                           key_accept
);

    logic [calc_pkg::COL_BITS-1:0]  col_index;
    logic [calc_pkg::KEY_COUNT-1:0] matrix;
    logic                           matrix_changed;
    logic                           matrix_empty;
    logic                           scan_en;
    logic                           timer_run;
    logic                           timer_clear;
    logic                           timer_done;
    logic                           process;
    logic                           digit_strobe;
    logic [3:0]                     digit;
    logic                           op_strobe;
    calc_pkg::calc_op_t             op;
    logic                           equal_strobe;
    logic                           clear_strobe;

    scan_timer u_scan_timer (
        .clk         (clk),
        .nRST        (nRST),
        .scan_en     (scan_en),
        .timer_run   (timer_run),
        .timer_clear (timer_clear),
        .col_index   (col_index),
        .timer_done  (timer_done)
    );

    keypad_scan_fsm u_scan_fsm (
        .clk            (clk),
        .nRST           (nRST),
        .matrix_changed (matrix_changed),
        .matrix_empty   (matrix_empty),
        .timer_done     (timer_done),
        .scan_en        (scan_en),
        .timer_run      (timer_run),
        .timer_clear    (timer_clear),
        .process        (process)
    );

    key_matrix u_key_matrix (
        .clk            (clk),
        .nRST           (nRST),
        .row            (row),
        .col_index      (col_index),
        .col            (col),
        .matrix         (matrix),
        .matrix_changed (matrix_changed),
        .matrix_empty   (matrix_empty)
    );

    key_decoder u_key_decoder (
        .clk          (clk),
        .nRST         (nRST),
        .process      (process),
        .matrix       (matrix),
        .digit_strobe (digit_strobe),
        .digit        (digit),
        .op_strobe    (op_strobe),
        .op           (op),
        .equal_strobe (equal_strobe),
        .clear_strobe (clear_strobe),
        .key_accept   (key_accept)
    );

    calc_core u_calc_core (
        .clk          (clk),
        .nRST         (nRST),
        .digit_strobe (digit_strobe),
        .digit        (digit),
        .op_strobe    (op_strobe),
        .op           (op),
        .equal_strobe (equal_strobe),
        .clear_strobe (clear_strobe),
        .display      (display),
        .result       (result),
        .result_valid (result_valid)
    );

endmodule

`default_nettype wire

// ==== verification/keypad_calc_tb.sv ====
`default_nettype none

module keypad_calc_tb;

    localparam int ACCEPT_TIMEOUT = 200;
    localparam int IDLE_CYCLES    = 3 * calc_pkg::DEBOUNCE_CYCLES;

    logic                           clk;
    logic                           nRST;
    logic [calc_pkg::NUM_ROWS-1:0]  row;
    logic [calc_pkg::NUM_COLS-1:0]  col;
    logic [calc_pkg::DATA_BITS-1:0] display;
    logic [calc_pkg::DATA_BITS-1:0] result;
    logic                           result_valid;
    logic                           key_accept;

    logic [calc_pkg::KEY_COUNT-1:0] held;  // Closed keys at slot col*4 + row
    logic [31:0]                    lfsr;
    int                             errors;
    int                             accept_count = 0;

    keypad_calc_top dut (
        .clk          (clk),
        .nRST         (nRST),
        .row          (row),
        .col          (col),
        .display      (display),
        .result       (result),
        .result_valid (result_valid),
        .key_accept   (key_accept)
    );

    always #10 clk = ~clk;

    // A closed key pulls its row low while its column is driven
    always_comb begin
        row = '1;
        for (int c = 0; c < calc_pkg::NUM_COLS; c++) begin
            for (int r = 0; r < calc_pkg::NUM_ROWS; r++) begin
                if (!col[c] && held[c*calc_pkg::NUM_ROWS + r]) begin
                    row[r] = 1'b0;
                end
            end
        end
    end

    always @(negedge clk) begin
        if (nRST && key_accept) begin
            accept_count++;
        end
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // Taps 32, 22, 2, 1
    endfunction

    function automatic int key_slot(input byte key);
        string layout = "147*2580369#ABCD";  // Column by column from the top row
        for (int i = 0; i < calc_pkg::KEY_COUNT; i++) begin
            if (layout[i] == key) begin
                return i;
            end
        end
        return -1;
    endfunction

    task automatic tick();
        @(posedge clk);
        #2;
    endtask

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        if (got !== exp) begin
            $display("ERROR %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    // Three LFSR bits give 1 to 7 cycles
    task automatic bounce_length(output int len);
        len = 0;
        for (int i = 0; i < 3; i++) begin
            lfsr = lfsr_next(lfsr);
            len  = len * 2 + lfsr[0];
        end
        if (len == 0) begin
            len = 1;
        end
    endtask

    task automatic bounce(input int slot, input int pulses);
        int len;
        for (int p = 0; p < pulses; p++) begin
            bounce_length(len);
            held[slot] = ~held[slot];
            repeat (len) tick();
        end
    endtask

    // Also catches an early accept during bounce
    task automatic wait_accept(input int start_count, output bit seen);
        seen = (accept_count != start_count);
        for (int i = 0; i < ACCEPT_TIMEOUT && !seen; i++) begin
            tick();
            seen = key_accept || (accept_count != start_count);
        end
    endtask

    task automatic press_key(input byte key, input byte key2, input byte mode,
                             input logic [15:0] exp_display, input logic [15:0] exp_result,
                             input bit is_equal);
        int slot;
        int len;
        int start_count;
        bit seen;
        bit expect_accept;
        slot = key_slot(key);
        if (slot < 0 || (mode == "m" && key_slot(key2) < 0)) begin
            $display("Pattern line names an unknown key %c", key);
            errors++;
            return;
        end
        expect_accept = (mode == "p" || mode == "b");
        start_count   = accept_count;
        if (mode == "b") begin
            bounce(slot, 4);  // Ends open
        end
        if (mode == "m") begin
            held[key_slot(key2)] = 1'b1;  // Second key for the rollover case
        end
        held[slot] = 1'b1;
        if (mode == "s") begin
            bounce_length(len);  // Well under half the debounce interval
            repeat (len) tick();
            held = '0;
        end
        wait_accept(start_count, seen);
        if (seen && !expect_accept) begin
            $display("Key %c was accepted although it should be ignored", key);
            errors++;
        end else if (!seen && expect_accept) begin
            $display("Key %c was not accepted within %0d cycles", key, ACCEPT_TIMEOUT);
            errors++;
        end
        tick();
        check_value("display", display, exp_display);
        check_value("result_valid", {15'b0, result_valid}, {15'b0, is_equal});
        if (is_equal) begin
            check_value("result", result, exp_result);
        end
        if (mode == "b") begin
            bounce(slot, 4);
        end
        held = '0;
        repeat (IDLE_CYCLES) tick();
        check_value("key_accept count", accept_count - start_count, expect_accept);
    endtask

    initial begin
        int fd;
        int n;
        int test_num;
        int cur_test;
        int test_errors;
        int tests_run;
        int tests_failed;
        byte key;
        byte key2;
        byte mode;
        logic [15:0] exp_display;
        logic [15:0] exp_result;
        int chk;
        logic [8*128-1:0] line_buf;

        clk          = 1'b0;
        nRST         = 1'b0;
        held         = '0;
        lfsr         = 32'ha145_2610;
        errors       = 0;
        cur_test     = 0;
        test_errors  = 0;
        tests_run    = 0;
        tests_failed = 0;
        repeat (8) tick();
        check_value("col", {12'b0, col}, 16'h000F);
        check_value("key_accept", {15'b0, key_accept}, 16'h0000);
        check_value("result_valid", {15'b0, result_valid}, 16'h0000);
        check_value("display", display, 16'h0000);
        check_value("result", result, 16'h0000);
        nRST = 1'b1;

        fd = $fopen("verification/calc_patterns.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the pattern file");
            errors++;
        end else begin
            line_buf = '0;
            while ($fgets(line_buf, fd) != 0) begin
                n = $sscanf(line_buf, "%d %c %c %c %h %h %d",
                            test_num, key, key2, mode, exp_display, exp_result, chk);
                if (n == 7) begin
                    if (test_num != cur_test && cur_test != 0) begin
                        tests_run++;
                        if (errors == test_errors) begin
                            $display("Test %0d passed", cur_test);
                        end else begin
                            $display("Test %0d failed, %0d errors", cur_test,
                                     errors - test_errors);
                            tests_failed++;
                        end
                    end
                    if (test_num != cur_test) begin
                        cur_test    = test_num;
                        test_errors = errors;
                    end
                    press_key(key, key2, mode, exp_display, exp_result, chk != 0);
                end else if (n > 0) begin
                    $display("Pattern line could not be read completely");
                    errors++;
                end
                line_buf = '0;
            end
            $fclose(fd);
            if (cur_test != 0) begin
                tests_run++;
                if (errors == test_errors) begin
                    $display("Test %0d passed", cur_test);
                end else begin
                    $display("Test %0d failed, %0d errors", cur_test, errors - test_errors);
                    tests_failed++;
                end
            end
        end

        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/calc_patterns.txt ====
// test key key2 mode display result check_result, display and result in hex
// mode p press, b bounced press, s short press, m held together with key2
1 1 - p 0001 0000 0
1 2 - p 000C 0000 0
1 0 - p 0078 0000 0
2 # - p 0000 0000 0
2 1 - p 0001 0000 0
2 2 - p 000C 0000 0
2 A - p 000C 0000 0
2 3 - p 0003 0000 0
2 0 - p 001E 0000 0
2 * - p 002A 002A 1
3 # - p 0000 0000 0
3 5 - p 0005 0000 0
3 0 - p 0032 0000 0
3 B - p 0032 0000 0
3 8 - p 0008 0000 0
3 * - p 002A 002A 1
4 # - p 0000 0000 0
4 6 - p 0006 0000 0
4 C - p 0006 0000 0
4 7 - p 0007 0000 0
4 * - p 002A 002A 1
5 # - p 0000 0000 0
5 2 - p 0002 0000 0
5 A - p 0002 0000 0
5 3 - p 0003 0000 0
5 C - p 0005 0000 0
5 4 - p 0004 0000 0
5 * - p 0014 0014 1
6 # - p 0000 0000 0
6 5 - p 0005 0000 0
6 D - p FFFB 0000 0
6 A - p FFFB 0000 0
6 3 - p 0003 0000 0
6 * - p FFFE FFFE 1
7 # - p 0000 0000 0
7 3 - p 0003 0000 0
7 0 - p 001E 0000 0
7 0 - p 012C 0000 0
7 C - p 012C 0000 0
7 3 - p 0003 0000 0
7 0 - p 001E 0000 0
7 0 - p 012C 0000 0
7 * - p 5F90 5F90 1
8 # - p 0000 0000 0
8 4 - p 0004 0000 0
8 * - p 0004 0004 1
9 # - p 0000 0000 0
9 9 - b 0009 0000 0
10 5 - s 0009 0000 0
11 # - p 0000 0000 0
11 1 - p 0001 0000 0
11 5 A m 0001 0000 0

// ==== compile.f ====
hw/calc_pkg.sv
hw/scan_timer.sv
hw/keypad_scan_fsm.sv
hw/key_matrix.sv
hw/key_decoder.sv
hw/calc_core.sv
hw/keypad_calc_top.sv
verification/keypad_calc_tb.sv
